// ==== ecc_pkg.sv ====
//####################################################################
// Shared ECC definitions: code widths, Hsiao column table, FSM states
// Bank access interface bank_if with initiator and target modports
//####################################################################

package ecc_pkg;

  localparam int unsigned DataWidth   = 32;
  localparam int unsigned ParityWidth = 7;
  localparam int unsigned CodeWidth   = DataWidth + ParityWidth;
  localparam int unsigned BeWidth     = DataWidth / 8;

  // Weight-3 columns of the check matrix, entry i belongs to data bit i
  localparam logic [ParityWidth-1:0] HsiaoCols [DataWidth] = '{
    7'h07, 7'h0B, 7'h13, 7'h23, 7'h43, 7'h0D, 7'h15, 7'h25,
    7'h45, 7'h19, 7'h29, 7'h49, 7'h31, 7'h51, 7'h61, 7'h0E,
    7'h16, 7'h26, 7'h46, 7'h1A, 7'h2A, 7'h4A, 7'h32, 7'h52,
    7'h62, 7'h1C, 7'h2C, 7'h4C, 7'h34, 7'h54, 7'h64, 7'h38
  };

  typedef enum logic [1:0] {
    NORMAL,
    LOAD_AND_STORE,
    UPDATE_CORRECTED
  } store_state_e;

  typedef enum logic [1:0] {
    SCRUB_IDLE,
    SCRUB_READ,
    SCRUB_CHECK,
    SCRUB_FIX
  } scrub_state_e;

endpackage

// Write when req and we, read when req alone with rdata one cycle later
interface bank_if import ecc_pkg::*; #(
  parameter  int unsigned BankSize  = 256,
  localparam int unsigned AddrWidth = $clog2(BankSize)
);

  logic                 req;
  logic                 we;
  logic [AddrWidth-1:0] addr;
  logic [CodeWidth-1:0] wdata;
  logic [CodeWidth-1:0] rdata;

  modport initiator (output req, output we, output addr, output wdata, input rdata);
  modport target    (input req, input we, input addr, input wdata, output rdata);

endinterface

// ==== secded_enc.sv ====
//####################################################################
// Hsiao (39,32) SECDED encoder
// Check bits are placed above the data bits in the codeword
//####################################################################

module secded_enc import ecc_pkg::*; (
  input  logic [DataWidth-1:0] data_i,
  output logic [CodeWidth-1:0] code_o
);

  logic [ParityWidth-1:0] parity;

  // Each set data bit toggles the check bits of its column
  always_comb begin
    parity = '0;
    for (int i = 0; i < DataWidth; i++) begin
      if (data_i[i]) begin
        parity = parity ^ HsiaoCols[i];
      end
    end
  end

  assign code_o = {parity, data_i}; // All-zero word encodes to all-zero code

endmodule

// ==== secded_dec.sv ====
//####################################################################
// Hsiao (39,32) SECDED decoder
// Corrects one flipped bit, flags single and double errors
//####################################################################

module secded_dec import ecc_pkg::*; (
  input  logic [CodeWidth-1:0] code_i,
  output logic [DataWidth-1:0] data_o,
  output logic                 single_o,
  output logic                 double_o
);

  logic [ParityWidth-1:0] syndrome;
  logic [DataWidth-1:0]   flip;
  logic                   check_hit;

  // Recompute parity over the data and compare with the stored check bits
  always_comb begin
    syndrome = code_i[CodeWidth-1:DataWidth];
    for (int i = 0; i < DataWidth; i++) begin
      if (code_i[i]) begin
        syndrome = syndrome ^ HsiaoCols[i];
      end
    end
  end

  // A syndrome equal to a data column points at the bad data bit
  always_comb begin
    flip = '0;
    for (int i = 0; i < DataWidth; i++) begin
      flip[i] = (syndrome == HsiaoCols[i]);
    end
  end

  assign check_hit = $onehot(syndrome); // Error sits in a check bit, data is fine
  assign single_o  = (|flip) | check_hit;
  assign double_o  = (syndrome != '0) & ~single_o; // Even weight or unknown pattern
  assign data_o    = code_i[DataWidth-1:0] ^ flip;

endmodule

// ==== ecc_sram_ctrl.sv ====
//####################################################################
// Bus side ECC controller
// Encodes stores, turns partial stores into read-modify-write,
// decodes loads and writes corrected words back to the bank
//####################################################################

module ecc_sram_ctrl import ecc_pkg::*; #(
  parameter  int unsigned BankSize  = 256,
  localparam int unsigned AddrWidth = $clog2(BankSize)
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  logic                 we_i,
  input  logic [AddrWidth-1:0] addr_i,
  input  logic [BeWidth-1:0]   be_i,
  input  logic [DataWidth-1:0] wdata_i,
  output logic                 gnt_o,
  output logic [DataWidth-1:0] rdata_o,
  output logic                 single_error_o,
  output logic                 multi_error_o,
  bank_if.initiator            ctrl_bus
);

  store_state_e state_d, state_q;

  logic                 valid_load_d, valid_load_q;
  logic                 fix_pending;
  logic                 granted;
  logic [AddrWidth-1:0] add_buffer_q;
  logic [DataWidth-1:0] input_buffer_q;
  logic [BeWidth-1:0]   be_buffer_q;
  logic [DataWidth-1:0] corrected_q;
  logic [DataWidth-1:0] loaded;
  logic [DataWidth-1:0] be_mask;
  logic [DataWidth-1:0] merged;
  logic [DataWidth-1:0] to_store;
  logic                 dec_single, dec_double;

  secded_dec i_dec (
    .code_i   (ctrl_bus.rdata),
    .data_o   (loaded),
    .single_o (dec_single),
    .double_o (dec_double)
  );

  secded_enc i_enc (
    .data_i (to_store),
    .code_o (ctrl_bus.wdata)
  );

  assign rdata_o        = loaded;
  assign single_error_o = dec_single & valid_load_q; // Only loads raise the flags
  assign multi_error_o  = dec_double & valid_load_q;
  assign fix_pending    = valid_load_q & dec_single;
  assign granted        = req_i & gnt_o;
  assign valid_load_d   = granted & ~we_i;

  // Byte merge of the buffered store into the old word
  always_comb begin
    for (int i = 0; i < BeWidth; i++) begin
      be_mask[i*8 +: 8] = {8{be_buffer_q[i]}};
    end
  end
  assign merged = (be_mask & input_buffer_q) | (~be_mask & loaded);

  always_comb begin
    state_d       = NORMAL;
    gnt_o         = 1'b1;
    ctrl_bus.req  = req_i;
    ctrl_bus.we   = we_i;
    ctrl_bus.addr = addr_i;
    to_store      = wdata_i;
    unique case (state_q)
      NORMAL: begin
        if (fix_pending) begin
          gnt_o        = 1'b0; // Hold the bus for the write-back
          ctrl_bus.req = 1'b0;
          state_d      = UPDATE_CORRECTED;
        end else if (req_i && we_i && (be_i != '1)) begin
          ctrl_bus.we = 1'b0;  // Fetch old word first
          state_d     = LOAD_AND_STORE;
        end
      end
      LOAD_AND_STORE: begin
        gnt_o         = 1'b0;
        ctrl_bus.req  = 1'b1;
        ctrl_bus.we   = 1'b1;
        ctrl_bus.addr = add_buffer_q;
        to_store      = merged;
      end
      UPDATE_CORRECTED: begin
        gnt_o         = 1'b0;
        ctrl_bus.req  = 1'b1;
        ctrl_bus.we   = 1'b1;
        ctrl_bus.addr = add_buffer_q;
        to_store      = corrected_q;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= NORMAL;
      valid_load_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      valid_load_q <= valid_load_d;
    end
  end

  // Request payload and corrected word
  always_ff @(posedge clk_i) begin
    if (granted) begin
      add_buffer_q   <= addr_i;
      input_buffer_q <= wdata_i;
      be_buffer_q    <= be_i;
    end
    if (fix_pending) begin
      corrected_q <= loaded;
    end
  end

endmodule

// ==== ecc_scrubber.sv ====
//####################################################################
// Background scrubber between controller and bank
// Passes controller traffic through and repairs words while idle
//####################################################################

module ecc_scrubber import ecc_pkg::*; #(
  parameter  int unsigned BankSize  = 256,
  localparam int unsigned AddrWidth = $clog2(BankSize)
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      scrub_trigger_i,
  output logic      scrubber_fix_o,
  output logic      scrub_uncorrectable_o,
  bank_if.target    ctrl_bus,
  bank_if.initiator mem_bus
);

  scrub_state_e state_d, state_q;

  logic [AddrWidth-1:0] scrub_addr_d, scrub_addr_q;
  logic [AddrWidth-1:0] next_addr;
  logic [DataWidth-1:0] checked_data;
  logic [DataWidth-1:0] fix_data_q;
  logic [CodeWidth-1:0] fix_code;
  logic                 dec_single, dec_double;
  logic                 scrub_req, scrub_we;

  secded_dec i_dec (
    .code_i   (mem_bus.rdata),
    .data_o   (checked_data),
    .single_o (dec_single),
    .double_o (dec_double)
  );

  secded_enc i_enc (
    .data_i (fix_data_q),
    .code_o (fix_code)
  );

  assign ctrl_bus.rdata = mem_bus.rdata;
  assign next_addr = (scrub_addr_q == AddrWidth'(BankSize - 1)) ? '0 :
                     scrub_addr_q + AddrWidth'(1);

  // Controller always wins the bank
  always_comb begin
    mem_bus.req = ctrl_bus.req | scrub_req;
    if (ctrl_bus.req) begin
      mem_bus.we    = ctrl_bus.we;
      mem_bus.addr  = ctrl_bus.addr;
      mem_bus.wdata = ctrl_bus.wdata;
    end else begin
      mem_bus.we    = scrub_we;
      mem_bus.addr  = scrub_addr_q;
      mem_bus.wdata = fix_code;
    end
  end

  always_comb begin
    state_d               = state_q;
    scrub_addr_d          = scrub_addr_q;
    scrub_req             = 1'b0;
    scrub_we              = 1'b0;
    scrubber_fix_o        = 1'b0;
    scrub_uncorrectable_o = 1'b0;
    unique case (state_q)
      SCRUB_IDLE: if (scrub_trigger_i) state_d = SCRUB_READ;
      SCRUB_READ: begin
        if (!ctrl_bus.req) begin
          scrub_req = 1'b1;
          state_d   = SCRUB_CHECK;
        end
      end
      SCRUB_CHECK: begin
        if (ctrl_bus.req) begin
          state_d = SCRUB_READ; // Bank stolen so the word may be stale
        end else begin
          scrubber_fix_o        = dec_single;
          scrub_uncorrectable_o = dec_double;
          if (dec_single) begin
            state_d = SCRUB_FIX;
          end else begin
            scrub_addr_d = next_addr; // Clean or uncorrectable words move on
            state_d      = SCRUB_IDLE;
          end
        end
      end
      SCRUB_FIX: begin
        if (ctrl_bus.req) begin
          state_d = SCRUB_READ;
        end else begin
          scrub_req    = 1'b1;
          scrub_we     = 1'b1;
          scrub_addr_d = next_addr;
          state_d      = SCRUB_IDLE;
        end
      end
      default: state_d = SCRUB_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= SCRUB_IDLE;
      scrub_addr_q <= '0;
    end else begin
      state_q      <= state_d;
      scrub_addr_q <= scrub_addr_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == SCRUB_CHECK) fix_data_q <= checked_data;
  end

endmodule

// ==== sram_bank.sv ====
//####################################################################
// Single-port 39-bit SRAM model
// Bitwise write mask, registered read port with one cycle latency
//####################################################################

module sram_bank import ecc_pkg::*; #(
  parameter int unsigned BankSize = 256
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  bank_if.target               mem_bus,
  input  logic [CodeWidth-1:0] write_mask_i // 1 keeps the stored bit
);

  logic [CodeWidth-1:0] mem_q [BankSize];
  logic [CodeWidth-1:0] rdata_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q   <= '{default: '0};
      rdata_q <= '0;
    end else if (mem_bus.req) begin
      if (mem_bus.we) begin
        mem_q[mem_bus.addr] <= (mem_bus.wdata & ~write_mask_i) |
                               (mem_q[mem_bus.addr] & write_mask_i);
      end else begin
        rdata_q <= mem_q[mem_bus.addr];
      end
    end
  end

  assign mem_bus.rdata = rdata_q; // Holds last read until the next one

endmodule

// ==== ecc_sram_top.sv ====
//####################################################################
// ECC protected SRAM top level
// Controller, scrubber and bank joined by two bank_if links
//####################################################################

module ecc_sram_top import ecc_pkg::*; #(
  parameter  int unsigned BankSize  = 256,
  localparam int unsigned AddrWidth = $clog2(BankSize)
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  logic                 we_i,
  input  logic [AddrWidth-1:0] addr_i,   // Word address
  input  logic [BeWidth-1:0]   be_i,
  input  logic [DataWidth-1:0] wdata_i,
  output logic                 gnt_o,
  output logic [DataWidth-1:0] rdata_o,
  output logic                 single_error_o,
  output logic                 multi_error_o,
  input  logic                 scrub_trigger_i,
  output logic                 scrubber_fix_o,
  output logic                 scrub_uncorrectable_o,
  input  logic [CodeWidth-1:0] write_mask_i // Keep at zero while scrubbing
);

  bank_if #(.BankSize(BankSize)) ctrl_bus ();
  bank_if #(.BankSize(BankSize)) mem_bus ();

  ecc_sram_ctrl #(.BankSize(BankSize)) i_ctrl (
    .clk_i,
    .rst_ni,
    .req_i,
    .we_i,
    .addr_i,
    .be_i,
    .wdata_i,
    .gnt_o,
    .rdata_o,
    .single_error_o,
    .multi_error_o,
    .ctrl_bus (ctrl_bus.initiator)
  );

  ecc_scrubber #(.BankSize(BankSize)) i_scrubber (
    .clk_i,
    .rst_ni,
    .scrub_trigger_i,
    .scrubber_fix_o,
    .scrub_uncorrectable_o,
    .ctrl_bus (ctrl_bus.target),
    .mem_bus  (mem_bus.initiator)
  );

  sram_bank #(.BankSize(BankSize)) i_bank (
    .clk_i,
    .rst_ni,
    .mem_bus      (mem_bus.target),
    .write_mask_i
  );

endmodule

// ==== tb_ecc_sram.sv ====
//####################################################################
// Testbench for the ECC protected SRAM top level
// Runs the operations of ecc_cases.txt and checks data, flags and
// scrubber pulses against the expected columns of each line
//####################################################################

module tb_ecc_sram import ecc_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned BankSize    = 256;
  localparam int unsigned AddrWidth   = $clog2(BankSize);
  localparam int unsigned MaxWait     = 200;
  localparam int unsigned ResetCycles = 4;

  logic                 clk_i = 1'b0;
  logic                 rst_ni;
  logic                 req_i;
  logic                 we_i;
  logic [AddrWidth-1:0] addr_i;
  logic [BeWidth-1:0]   be_i;
  logic [DataWidth-1:0] wdata_i;
  logic                 gnt_o;
  logic [DataWidth-1:0] rdata_o;
  logic                 single_error_o;
  logic                 multi_error_o;
  logic                 scrub_trigger_i;
  logic                 scrubber_fix_o;
  logic                 scrub_uncorrectable_o;
  logic [CodeWidth-1:0] write_mask_i;

  int unsigned error_count;
  int unsigned check_count;
  int unsigned case_count;
  bit          case_failed;
  bit          timed_out;

  ecc_sram_top #(.BankSize(BankSize)) UUT (
    .clk_i,
    .rst_ni,
    .req_i,
    .we_i,
    .addr_i,
    .be_i,
    .wdata_i,
    .gnt_o,
    .rdata_o,
    .single_error_o,
    .multi_error_o,
    .scrub_trigger_i,
    .scrubber_fix_o,
    .scrub_uncorrectable_o,
    .write_mask_i
  );

  always #4 clk_i = ~clk_i; // 8 ns period

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    check_count++;
    if (actual !== expected) begin
      $display("ERROR %s: expected 0x%0h, got 0x%0h", name, expected, actual);
      error_count++;
      case_failed = 1'b1;
    end
  endtask

  // Request stays asserted until the controller grants it
  task automatic wait_for_grant();
    int unsigned waited;
    waited = 0;
    while (!gnt_o && !timed_out) begin
      @(negedge clk_i);
      waited++;
      if (!gnt_o && waited >= MaxWait) begin
        $display("Timeout, gnt_o stayed low for %0d cycles", MaxWait);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic run_access(input logic [7:0] op, input logic [31:0] addr,
                            input logic [31:0] be, input logic [31:0] wdata,
                            input logic [63:0] mask, input logic [31:0] exp_rdata,
                            input logic exp_single, input logic exp_multi);
    @(negedge clk_i);
    req_i        = 1'b1;
    we_i         = (op == "W");
    addr_i       = addr[AddrWidth-1:0];
    be_i         = be[BeWidth-1:0];
    wdata_i      = wdata;
    write_mask_i = mask[CodeWidth-1:0];
    wait_for_grant();
    if (timed_out) begin
      req_i        = 1'b0;
      write_mask_i = '0;
      return;
    end
    @(negedge clk_i); // Cycle after the grant
    req_i = 1'b0;
    if (we_i) begin
      if (be_i != '1) check_value("gnt_o", 64'd0, 64'(gnt_o)); // RMW write cycle
    end else begin
      check_value("rdata_o", 64'(exp_rdata), 64'(rdata_o));
      check_value("single_error_o", 64'(exp_single), 64'(single_error_o));
      check_value("multi_error_o", 64'(exp_multi), 64'(multi_error_o));
    end
    @(negedge clk_i);
    if (!we_i && exp_single) check_value("gnt_o", 64'd0, 64'(gnt_o)); // Write-back
    write_mask_i = '0; // Mask held through the RMW write
  endtask

  task automatic run_scrub(input logic exp_fix, input logic exp_unc);
    int unsigned waited;
    waited = 0;
    @(negedge clk_i);
    scrub_trigger_i = 1'b1;
    while (!scrubber_fix_o && !scrub_uncorrectable_o && !timed_out) begin
      @(negedge clk_i);
      waited++;
      if (!scrubber_fix_o && !scrub_uncorrectable_o && waited >= MaxWait) begin
        $display("Timeout, the scrubber gave no pulse within %0d cycles", MaxWait);
        timed_out = 1'b1;
      end
    end
    scrub_trigger_i = 1'b0;
    if (!timed_out) begin
      check_value("scrubber_fix_o", 64'(exp_fix), 64'(scrubber_fix_o));
      check_value("scrub_uncorrectable_o", 64'(exp_unc), 64'(scrub_uncorrectable_o));
    end
  endtask

  task automatic run_case(input logic [7:0] op, input logic [31:0] addr,
                          input logic [31:0] be, input logic [31:0] wdata,
                          input logic [63:0] mask, input logic [31:0] exp_rdata,
                          input logic exp_single, input logic exp_multi);
    case_failed = 1'b0;
    case_count++;
    case (op)
      "W", "R": run_access(op, addr, be, wdata, mask, exp_rdata, exp_single, exp_multi);
      "S":      run_scrub(exp_single, exp_multi);
      default: begin
        $display("Unknown operation %c in the cases file", op);
        error_count++;
        case_failed = 1'b1;
      end
    endcase
    if (timed_out) case_failed = 1'b1;
    $display("case %0d %c addr 0x%0h %s", case_count, op, addr,
             case_failed ? "failed" : "ok");
    repeat (2) @(negedge clk_i); // Let a pending scrub fix land
  endtask

  initial begin
    int          fd;
    int          fields;
    string       line;
    logic [7:0]  op;
    logic [31:0] f_addr, f_be, f_wdata, f_rdata, f_single, f_multi;
    logic [63:0] f_mask;
    rst_ni          = 1'b0;
    req_i           = 1'b0;
    we_i            = 1'b0;
    addr_i          = '0;
    be_i            = '0;
    wdata_i         = '0;
    scrub_trigger_i = 1'b0;
    write_mask_i    = '0;
    error_count     = 0;
    check_count     = 0;
    case_count      = 0;
    timed_out       = 1'b0;
    repeat (ResetCycles) @(negedge clk_i);
    rst_ni = 1'b1;
    fd = $fopen("ecc_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open ecc_cases.txt for reading");
      error_count++;
    end else begin
      while (!timed_out && $fgets(line, fd) != 0) begin
        fields = $sscanf(line, "%c %h %h %h %h %h %h %h", op, f_addr, f_be, f_wdata,
                         f_mask, f_rdata, f_single, f_multi);
        if (fields == 8 && op != "#") begin
          run_case(op, f_addr, f_be, f_wdata, f_mask, f_rdata, f_single[0], f_multi[0]);
        end
      end
      $fclose(fd);
    end
    if (timed_out) error_count++;
    $display("%0d cases, %0d checks, %0d errors", case_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== ecc_cases.txt ====
# Columns are op, addr, be, wdata, mask, expected rdata, expected single, expected multi in hex
# Ops are W store, R load and S scrub, where S flags mean the fix and uncorrectable pulses
W 10 f 12345678 0000000000 00000000 0 0
R 10 f 00000000 0000000000 12345678 0 0
W 10 3 aabbccdd 0000000000 00000000 0 0
R 10 f 00000000 0000000000 1234ccdd 0 0
W 10 5 11223344 0000000000 00000000 0 0
R 10 f 00000000 0000000000 1222cc44 0 0
W 20 f deadbeef 0000000001 00000000 0 0
R 20 f 00000000 0000000000 deadbeef 1 0
R 20 f 00000000 0000000000 deadbeef 0 0
W 28 f 00000001 0100000000 00000000 0 0
R 28 f 00000000 0000000000 00000001 1 0
R 28 f 00000000 0000000000 00000001 0 0
W 30 f 00000003 0000000003 00000000 0 0
R 30 f 00000000 0000000000 00000000 0 1
W 04 f 0000ff00 0000000100 00000000 0 0
W 08 f a5a5a5a5 0000000005 00000000 0 0
S 00 0 00000000 0000000000 00000000 1 0
R 04 f 00000000 0000000000 0000ff00 0 0
S 00 0 00000000 0000000000 00000000 0 1
R 08 f 00000000 0000000000 a5a5a5a0 0 1

// ==== files.f ====
ecc_pkg.sv
secded_enc.sv
secded_dec.sv
ecc_sram_ctrl.sv
ecc_scrubber.sv
sram_bank.sv
ecc_sram_top.sv
tb_ecc_sram.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ecc_sram
RTL_TOP   ?= ecc_sram_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= Done: no errors

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
